/* logic/fcs_macros.svh */
// ------------------------------
// beat geometry and CRC-32 constants
// ------------------------------
`ifndef FCS_MACROS_SVH
`define FCS_MACROS_SVH

// byte lanes in one beat
`define FCS_LANES 8
`define FCS_DATA_W 64
`define FCS_KEEP_W 8

// reflected CRC-32, 04C11DB7 bit-reversed
`define FCS_CRC_W 32
`define FCS_CRC_POLY 32'hEDB8_8320
`define FCS_CRC_INIT 32'hFFFF_FFFF

`endif

/* logic/fcs_pkg.sv */
// ------------------------------
// beat struct and FSM state enum
// ------------------------------
`include "fcs_macros.svh"

package fcs_pkg;

    // one stream beat, lane 0 in data[7:0]
    typedef struct packed {
        logic [`FCS_DATA_W-1:0] data;
        logic [`FCS_KEEP_W-1:0] keep;
        logic                   last;
        logic                   user;
    } beat_t;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_PAYLOAD = 2'd1,
        ST_FCS     = 2'd2
    } fcs_state_e;

endpackage

/* logic/eth_crc_lanes.sv */
// ------------------------------
// CRC-32 state after 1..8 bytes
// ------------------------------
`timescale 1ns/1ps
`include "fcs_macros.svh"

module eth_crc_lanes (
    input  logic [`FCS_CRC_W-1:0]                   crc_state,
    input  logic [`FCS_DATA_W-1:0]                  data,
    output logic [`FCS_LANES-1:0][`FCS_CRC_W-1:0]   crc_next
);

    // walk the bytes lane by lane, tapping the state after each one
    always_comb begin : crc_walk
        logic [`FCS_CRC_W-1:0] c;
        c = crc_state;
        for (int b = 0; b < `FCS_LANES; b++) begin
            c = c ^ {24'd0, data[b*8 +: 8]};
            for (int i = 0; i < 8; i++) begin
                if (c[0]) begin
                    c = (c >> 1) ^ `FCS_CRC_POLY;
                end else begin
                    c = c >> 1;
                end
            end
            crc_next[b] = c;
        end
    end

endmodule

/* logic/fcs_tail_merge.sv */
// ------------------------------
// FCS placement into final beat
// and optional spill beat
// ------------------------------
`timescale 1ns/1ps
`include "fcs_macros.svh"

module fcs_tail_merge (
    input  logic [`FCS_DATA_W-1:0]                  data,
    input  logic [`FCS_KEEP_W-1:0]                  keep,
    input  logic [`FCS_LANES-1:0][`FCS_CRC_W-1:0]   crc_next,
    output fcs_pkg::beat_t                          tail_beat,
    output fcs_pkg::beat_t                          spill_beat,
    output logic                                    spill
);

    logic [3:0]                  n_bytes;
    logic [2:0]                  sel;
    logic [`FCS_CRC_W-1:0]       fcs;
    logic [2*`FCS_DATA_W-1:0]    wide_data;
    logic [2*`FCS_KEEP_W-1:0]    wide_keep;

    // keep is contiguous, so the popcount is the byte count
    always_comb begin
        n_bytes = 4'd0;
        for (int i = 0; i < `FCS_KEEP_W; i++) begin
            n_bytes = n_bytes + {3'd0, keep[i]};
        end
    end

    // eight bytes wraps to index 7
    assign sel = n_bytes[2:0] - 3'd1;
    assign fcs = ~crc_next[sel];

    // FCS lands right after the last valid byte, across two beats
    assign wide_data = {64'd0, data} | ({96'd0, fcs} << {n_bytes, 3'b000});
    assign wide_keep = {8'd0, keep} | (16'h000F << n_bytes);

    assign spill = (n_bytes > 4'd4);

    assign tail_beat.data  = wide_data[`FCS_DATA_W-1:0];
    assign tail_beat.keep  = wide_keep[`FCS_KEEP_W-1:0];
    assign tail_beat.last  = ~spill;
    assign tail_beat.user  = 1'b0;

    assign spill_beat.data = wide_data[2*`FCS_DATA_W-1:`FCS_DATA_W];
    assign spill_beat.keep = wide_keep[2*`FCS_KEEP_W-1:`FCS_KEEP_W];
    assign spill_beat.last = 1'b1;
    assign spill_beat.user = 1'b0;

endmodule

/* logic/fcs_insert_ctrl.sv */
// ------------------------------
// lane masking, frame FSM,
// CRC and spill registers
// ------------------------------
`timescale 1ns/1ps
`include "fcs_macros.svh"

module fcs_insert_ctrl (
    input  logic                                    clk,
    input  logic                                    rst,
    input  fcs_pkg::beat_t                          in_beat,
    input  logic                                    in_valid,
    output logic                                    in_ready,
    output logic [`FCS_CRC_W-1:0]                   crc_state,
    output logic [`FCS_DATA_W-1:0]                  data_masked,
    input  logic [`FCS_LANES-1:0][`FCS_CRC_W-1:0]   crc_next,
    input  fcs_pkg::beat_t                          tail_beat,
    input  fcs_pkg::beat_t                          spill_beat,
    input  logic                                    spill,
    output fcs_pkg::beat_t                          buf_beat,
    output logic                                    buf_valid,
    input  logic                                    buf_ready,
    input  logic                                    buf_ready_early
);

    fcs_pkg::fcs_state_e state, state_next;
    logic                in_ready_reg, in_ready_next;
    logic                crc_reset, crc_update, spill_store;
    logic                accept;
    fcs_pkg::beat_t      spill_reg;

    always_comb begin
        for (int i = 0; i < `FCS_LANES; i++) begin
            data_masked[i*8 +: 8] = in_beat.keep[i] ? in_beat.data[i*8 +: 8] : 8'd0;
        end
    end

    assign in_ready  = in_ready_reg;
    assign accept    = in_valid && in_ready_reg;

    always_comb begin
        state_next    = state;
        in_ready_next = buf_ready_early;
        crc_reset     = 1'b0;
        crc_update    = 1'b0;
        spill_store   = 1'b0;
        buf_beat.data = data_masked;
        buf_beat.keep = in_beat.keep;
        buf_beat.last = 1'b0;
        buf_beat.user = 1'b0;
        buf_valid     = accept;

        case (state)
            fcs_pkg::ST_IDLE, fcs_pkg::ST_PAYLOAD: begin
                if (accept && !in_beat.last) begin
                    crc_update = 1'b1;
                    state_next = fcs_pkg::ST_PAYLOAD;
                end else if (accept && in_beat.user) begin
                    // bad frame goes out untouched
                    buf_beat.last = 1'b1;
                    buf_beat.user = 1'b1;
                    crc_reset     = 1'b1;
                    state_next    = fcs_pkg::ST_IDLE;
                end else if (accept) begin
                    buf_beat   = tail_beat;
                    crc_reset  = 1'b1;
                    state_next = fcs_pkg::ST_IDLE;
                    if (spill) begin
                        spill_store   = 1'b1;
                        in_ready_next = 1'b0;
                        state_next    = fcs_pkg::ST_FCS;
                    end
                end
            end
            fcs_pkg::ST_FCS: begin
                buf_beat      = spill_reg;
                buf_valid     = 1'b1;
                in_ready_next = 1'b0;
                if (buf_ready) begin
                    in_ready_next = buf_ready_early;
                    state_next    = fcs_pkg::ST_IDLE;
                end
            end
            default: begin
                state_next = fcs_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= fcs_pkg::ST_IDLE;
            in_ready_reg <= 1'b0;
            crc_state    <= `FCS_CRC_INIT;
        end else begin
            state        <= state_next;
            in_ready_reg <= in_ready_next;
            if (crc_reset) begin
                crc_state <= `FCS_CRC_INIT;
            end else if (crc_update) begin
                crc_state <= crc_next[`FCS_LANES-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (spill_store) begin
            spill_reg <= spill_beat;
        end
    end

    // keep must be a run of ones from lane 0
    assert property (@(posedge clk) disable iff (rst)
        accept |-> (in_beat.keep != '0) && ((in_beat.keep & (in_beat.keep + 8'd1)) == '0));

    assert property (@(posedge clk) disable iff (rst)
        (state == fcs_pkg::ST_FCS && buf_valid) |-> buf_beat.last);

endmodule

/* logic/axis_skid_buffer.sv */
// ------------------------------
// registered output stage with
// one holding entry
// ------------------------------
`timescale 1ns/1ps

module axis_skid_buffer (
    input  logic           clk,
    input  logic           rst,
    input  fcs_pkg::beat_t buf_beat,
    input  logic           buf_valid,
    output logic           buf_ready,
    output logic           buf_ready_early,
    output fcs_pkg::beat_t out_beat,
    output logic           out_valid,
    input  logic           out_ready
);

    fcs_pkg::beat_t hold_beat;
    logic           hold_valid;
    logic           load_out, load_hold, hold_to_out;

    // holding entry stays empty unless a beat arrives while output stalls
    assign buf_ready_early = out_ready || (!hold_valid && (!out_valid || !buf_valid));

    always_comb begin
        load_out    = 1'b0;
        load_hold   = 1'b0;
        hold_to_out = 1'b0;
        if (buf_ready) begin
            if (out_ready || !out_valid) begin
                load_out = 1'b1;
            end else begin
                load_hold = 1'b1;
            end
        end else if (out_ready) begin
            hold_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            hold_valid <= 1'b0;
            buf_ready  <= 1'b0;
        end else begin
            buf_ready <= buf_ready_early;
            if (load_out) begin
                out_valid <= buf_valid;
            end else if (hold_to_out) begin
                out_valid  <= hold_valid;
                hold_valid <= 1'b0;
            end
            if (load_hold) begin
                hold_valid <= buf_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_beat <= buf_beat;
        end else if (hold_to_out) begin
            out_beat <= hold_beat;
        end
        if (load_hold) begin
            hold_beat <= buf_beat;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)));

endmodule

/* logic/fcs_insert_top.sv */
// ------------------------------
// FCS inserter top level
// ------------------------------
`timescale 1ns/1ps
`include "fcs_macros.svh"

module fcs_insert_top (
    input  logic           clk,
    input  logic           rst,
    input  fcs_pkg::beat_t in_beat,
    input  logic           in_valid,
    output logic           in_ready,
    output fcs_pkg::beat_t out_beat,
    output logic           out_valid,
    input  logic           out_ready
);

    logic [`FCS_CRC_W-1:0]                  crc_state;
    logic [`FCS_DATA_W-1:0]                 data_masked;
    logic [`FCS_LANES-1:0][`FCS_CRC_W-1:0]  crc_next;
    fcs_pkg::beat_t                         tail_beat, spill_beat, buf_beat;
    logic                                   spill;
    logic                                   buf_valid, buf_ready, buf_ready_early;

    fcs_insert_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .in_beat         (in_beat),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .crc_state       (crc_state),
        .data_masked     (data_masked),
        .crc_next        (crc_next),
        .tail_beat       (tail_beat),
        .spill_beat      (spill_beat),
        .spill           (spill),
        .buf_beat        (buf_beat),
        .buf_valid       (buf_valid),
        .buf_ready       (buf_ready),
        .buf_ready_early (buf_ready_early)
    );

    eth_crc_lanes u_crc (
        .crc_state (crc_state),
        .data      (data_masked),
        .crc_next  (crc_next)
    );

    fcs_tail_merge u_merge (
        .data       (data_masked),
        .keep       (in_beat.keep),
        .crc_next   (crc_next),
        .tail_beat  (tail_beat),
        .spill_beat (spill_beat),
        .spill      (spill)
    );

    axis_skid_buffer u_skid (
        .clk             (clk),
        .rst             (rst),
        .buf_beat        (buf_beat),
        .buf_valid       (buf_valid),
        .buf_ready       (buf_ready),
        .buf_ready_early (buf_ready_early),
        .out_beat        (out_beat),
        .out_valid       (out_valid),
        .out_ready       (out_ready)
    );

endmodule

/* bench/tb_clock_gen.sv */
// ------------------------------
// testbench clock and reset
// ------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // released on the 16th rising edge
    initial begin
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* bench/tb_fcs_checker.sv */
// ------------------------------
// CRC-32 reference model, output
// beat checks and frame counts
// ------------------------------
`timescale 1ns/1ps

module tb_fcs_checker (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_ready,
    input  fcs_pkg::beat_t out_beat,
    input  logic           out_valid,
    input  logic           out_ready,
    output int             frames_checked,
    output int             frames_failed,
    output int             errors
);

    localparam logic [31:0] crc_poly = 32'hEDB8_8320;

    logic [7:0]     exp_stream[$];
    int             exp_len[$];
    int             exp_plen[$];
    bit             exp_user[$];
    logic [31:0]    crc_run = 32'hFFFF_FFFF;
    int             plen = 0;
    int             rem = 0;
    int             cur_plen = 0;
    bit             cur_user = 1'b0;
    bit             cur_bad = 1'b0;
    bit             stalled = 1'b0;
    fcs_pkg::beat_t held_beat;
    logic           rst_d = 1'b0;
    int             reset_errors = 0;
    int             stream_errors = 0;

    assign errors = reset_errors + stream_errors;

    // bit serial, LSB of each byte first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ b[i]) begin
                c = {1'b0, c[31:1]} ^ crc_poly;
            end else begin
                c = {1'b0, c[31:1]};
            end
        end
        return c;
    endfunction

    function void push_byte(input logic [7:0] b);
        exp_stream.push_back(b);
        crc_run = crc_step(crc_run, b);
        plen++;
    endfunction

    // FCS goes out least significant byte first
    function void close_frame(input bit bad);
        logic [31:0] fcs;
        fcs = ~crc_run;
        if (!bad) begin
            for (int i = 0; i < 4; i++) begin
                exp_stream.push_back(fcs[i*8 +: 8]);
            end
        end
        exp_len.push_back(bad ? plen : plen + 4);
        exp_plen.push_back(plen);
        exp_user.push_back(bad);
        crc_run = 32'hFFFF_FFFF;
        plen = 0;
    endfunction

    function void compare_field(input string name, input logic [63:0] exp,
                                input logic [63:0] got);
        if (got !== exp) begin
            $display("Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
            stream_errors++;
            cur_bad = 1'b1;
        end
    endfunction

    function void check_beat(input fcs_pkg::beat_t b);
        fcs_pkg::beat_t e;
        int             cnt;
        if (rem == 0) begin
            if (exp_len.size() == 0) begin
                $display("Error at %0t: output beat arrived with no frame pending", $time);
                stream_errors++;
                return;
            end
            rem = exp_len.pop_front();
            cur_plen = exp_plen.pop_front();
            cur_user = exp_user.pop_front();
            cur_bad = 1'b0;
        end
        cnt = (rem > 8) ? 8 : rem;
        e = '0;
        for (int i = 0; i < cnt; i++) begin
            e.data[i*8 +: 8] = exp_stream.pop_front();
        end
        e.keep = 8'hFF >> (8 - cnt);
        e.last = (rem <= 8);
        e.user = e.last && cur_user;
        rem = rem - cnt;
        compare_field("out_beat.data", e.data, b.data);
        compare_field("out_beat.keep", {56'd0, e.keep}, {56'd0, b.keep});
        compare_field("out_beat.last", {63'd0, e.last}, {63'd0, b.last});
        compare_field("out_beat.user", {63'd0, e.user}, {63'd0, b.user});
        if (e.last) begin
            frames_checked++;
            if (cur_bad) begin
                frames_failed++;
                $display("frame %0d: %0d payload bytes, user %0b, FAILED",
                         frames_checked, cur_plen, cur_user);
            end else begin
                $display("frame %0d: %0d payload bytes, user %0b, ok",
                         frames_checked, cur_plen, cur_user);
            end
        end
    endfunction

    always @(posedge clk) begin
        rst_d <= rst;
        if (!rst) begin
            if (stalled && out_valid !== 1'b1) begin
                $display("Error at %0t: out_valid expected 1 got %b while stalled",
                         $time, out_valid);
                stream_errors++;
            end else if (stalled && out_beat !== held_beat) begin
                $display("Error at %0t: out_beat expected %0h got %0h while stalled",
                         $time, held_beat, out_beat);
                stream_errors++;
            end
            stalled = out_valid && !out_ready;
            held_beat = out_beat;
            if (out_valid && out_ready) begin
                check_beat(out_beat);
            end
        end
    end

    // in reset and one cycle after it
    always @(negedge clk) begin
        if (rst || rst_d) begin
            if (in_ready !== 1'b0) begin
                $display("Error at %0t: in_ready expected 0 got %b", $time, in_ready);
                reset_errors++;
            end
            if (out_valid !== 1'b0) begin
                $display("Error at %0t: out_valid expected 0 got %b", $time, out_valid);
                reset_errors++;
            end
            if (!rst) begin
                $display("reset: in_ready and out_valid checked, %0d errors", reset_errors);
            end
        end
    end

endmodule

/* bench/tb_fcs_insert.sv */
// ------------------------------
// FCS inserter testbench top:
// random frames and sink ready
// ------------------------------
`timescale 1ns/1ps

module tb_fcs_insert;

    localparam int n_frames       = 200;
    localparam int timeout_cycles = n_frames * 6 * 4 + 100;

    logic           clk;
    logic           rst;
    fcs_pkg::beat_t in_beat;
    logic           in_valid;
    logic           in_ready;
    fcs_pkg::beat_t out_beat;
    logic           out_valid;
    logic           out_ready = 1'b0;
    int             frames_checked;
    int             frames_failed;
    int             errors;
    int             seed = 32'h8193_b710;
    int             ready_seed = 32'h8193_b710;
    int             cycles = 0;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    fcs_insert_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    tb_fcs_checker u_check (
        .clk            (clk),
        .rst            (rst),
        .in_ready       (in_ready),
        .out_beat       (out_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .frames_checked (frames_checked),
        .frames_failed  (frames_failed),
        .errors         (errors)
    );

    function automatic logic [7:0] rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // sink ready about 70 % of cycles
    always @(posedge clk) begin
        out_ready <= ({$random(ready_seed)} % 10) < 7;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: only %0d of %0d frames came out after %0d cycles",
                     frames_checked, n_frames, cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic send_frame(input int len, input bit bad);
        logic [7:0]     payload [40];
        fcs_pkg::beat_t beat;
        int             nbeats;
        int             cnt;
        for (int i = 0; i < len; i++) begin
            payload[i] = rand_byte();
            u_check.push_byte(payload[i]);
        end
        u_check.close_frame(bad);
        nbeats = (len + 7) / 8;
        for (int k = 0; k < nbeats; k++) begin
            cnt = (k == nbeats - 1) ? len - 8 * k : 8;
            while (({$random(seed)} % 4) == 0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            // garbage in the unused lanes
            for (int i = 0; i < 8; i++) begin
                if (i < cnt) begin
                    beat.data[i*8 +: 8] = payload[8*k + i];
                end else begin
                    beat.data[i*8 +: 8] = rand_byte();
                end
            end
            beat.keep = 8'hFF >> (8 - cnt);
            beat.last = (k == nbeats - 1);
            beat.user = beat.last && bad;
            in_beat  <= beat;
            in_valid <= 1'b1;
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
        end
    endtask

    initial begin : stimulus
        int len;
        bit bad;
        in_valid <= 1'b0;
        in_beat  <= '0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        for (int f = 0; f < n_frames; f++) begin
            len = 1 + {$random(seed)} % 40;
            bad = ({$random(seed)} % 8) == 0;
            send_frame(len, bad);
        end
        in_valid <= 1'b0;
        while (frames_checked < n_frames) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("%0d frames checked, %0d passed, %0d failed, %0d error lines",
                 frames_checked, frames_checked - frames_failed, frames_failed, errors);
        if (frames_checked == n_frames && frames_failed == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+logic
logic/fcs_pkg.sv
logic/eth_crc_lanes.sv
logic/fcs_tail_merge.sv
logic/fcs_insert_ctrl.sv
logic/axis_skid_buffer.sv
logic/fcs_insert_top.sv
bench/tb_clock_gen.sv
bench/tb_fcs_checker.sv
bench/tb_fcs_insert.sv

/* run_sim.sh */
#!/bin/sh
# build and run the FCS inserter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fcs_insert -f build.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_fcs_insert > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
